// File: include/spi_config.svh
`ifndef SPI_CONFIG_SVH
`define SPI_CONFIG_SVH

// Bits shifted per frame, LSB first
`define SPI_WORD_BITS 16

// inner_clk cycles per sclk half period
`define SPI_CLK_DIV 4

// Entries in each word queue, power of two
`define SPI_FIFO_DEPTH 4

// Chip select level while the slave is addressed
`define SPI_CS_ACTIVE 1'b0

`endif

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_spi_subsystem -f src.f
out=$(./obj_dir/Vtb_spi_subsystem +verilator+error+limit+1000 || true)
echo "$out"
echo "$out" | grep -qx "Test passed"

// File: src.f
+incdir+include
verilog/spi_pkg.sv
verilog/spi_rate_gen.sv
verilog/spi_fifo.sv
verilog/spi_master.sv
verilog/spi_subsystem.sv
tests/spi_slave_model.sv
tests/spi_assert.sv
tests/tb_spi_subsystem.sv

// File: tests/spi_assert.sv
`timescale 1ns/1ns
`default_nettype none

`include "spi_config.svh"

module spi_assert import spi_pkg::*; (
    input wire logic      inner_clk,
    input wire logic      reset,
    input var spi_state_t state,
    input wire spi_pins_t pins,
    input wire logic      tx_take,
    input wire logic      rx_put,
    input wire logic      rx_full
);

    int fail_count = 0;  // Summed into the final result

    cs_idle: assert property (@(posedge inner_clk) disable iff (reset)
        (state == idle) |-> (pins.cs != `SPI_CS_ACTIVE)) else begin
        fail_count++;
        $error("cs active while the master is idle");
    end
    sclk_parked: assert property (@(posedge inner_clk) disable iff (reset)
        (pins.cs != `SPI_CS_ACTIVE) |-> pins.sclk) else begin
        fail_count++;
        $error("sclk low with the slave deselected");
    end
    // Strobes come from ticks, so they never sit next to each other
    single_pulse: assert property (@(posedge inner_clk) disable iff (reset)
        (tx_take || rx_put) |=> !(tx_take || rx_put)) else begin
        fail_count++;
        $error("tx_take or rx_put held longer than one cycle");
    end
    put_room: assert property (@(posedge inner_clk) disable iff (reset)
        rx_put |-> !rx_full) else begin
        fail_count++;
        $error("rx_put while the receive queue is full");
    end

endmodule

bind spi_master spi_assert spi_assert_inst (
    .inner_clk (inner_clk), .reset (reset), .state (state), .pins (pins),
    .tx_take (tx_take), .rx_put (rx_put), .rx_full (rx_full)
);

`default_nettype wire

// File: tests/spi_slave_model.sv
`timescale 1ns/1ns
`default_nettype none

`include "spi_config.svh"

module spi_slave_model import spi_pkg::*; (
    input  wire logic      reset,
    input  wire spi_pins_t pins,
    output logic           miso
);

    spi_word_t miso_words[$];   // Replies queued by the testbench
    spi_word_t mosi_frames[$];  // Received frames, oldest first
    int        rise_counts[$];  // sclk rises seen per frame
    int        frame_total = 0;
    spi_word_t out_word;
    spi_word_t in_word;
    int        bit_idx;
    logic      in_frame = 1'b0;
    logic      sclk_last = 1'b1;
    logic      miso_bit = 1'b0;

    assign miso = miso_bit;

    // cs and sclk never move in the same step, so one block follows both
    always @(pins or reset) begin
        if (!reset && pins.cs === `SPI_CS_ACTIVE && !in_frame) begin
            out_word = (miso_words.size() > 0) ? miso_words.pop_front() : '0;
            in_word  = '0;
            bit_idx  = 0;
            in_frame = 1'b1;
        end else if (pins.cs !== `SPI_CS_ACTIVE && in_frame) begin
            mosi_frames.push_back(in_word);
            rise_counts.push_back(bit_idx);  // One count per rise
            frame_total++;
            in_frame = 1'b0;
        end else if (in_frame && sclk_last === 1'b1 && pins.sclk === 1'b0) begin
            if (bit_idx < `SPI_WORD_BITS) begin
                miso_bit = out_word[bit_idx];  // Reply LSB first
            end
        end else if (in_frame && sclk_last === 1'b0 && pins.sclk === 1'b1) begin
            if (bit_idx < `SPI_WORD_BITS) begin
                in_word[bit_idx] = pins.mosi;
            end
            bit_idx++;
        end
        sclk_last = pins.sclk;
    end

endmodule

`default_nettype wire

// File: tests/tb_spi_subsystem.sv
`timescale 1ns/1ns
`default_nettype none

`include "spi_config.svh"

module tb_spi_subsystem import spi_pkg::*; ();

    localparam int   FRAME_CYCLES = 34 * `SPI_CLK_DIV;
    localparam int   CYCLE_LIMIT  = 40 * FRAME_CYCLES + 2000;
    localparam int   STREAM_WORDS = 30;
    localparam int   HOLD_WORDS   = 2 * `SPI_FIFO_DEPTH;
    localparam logic CS_IDLE      = ~`SPI_CS_ACTIVE;

    logic        inner_clk;
    logic        reset;
    logic        tx_push;
    spi_word_t   tx_data;
    logic        tx_full;
    logic        rx_pop;
    spi_word_t   rx_data;
    logic        rx_empty;
    logic        miso;
    spi_pins_t   pins;
    logic [31:0] lfsr;
    int          cycles = 0;
    int          value_errors = 0;
    int          other_errors = 0;
    int          base;
    logic        restarted;
    spi_word_t   exp_mosi[$];  // Words the slave should see
    spi_word_t   exp_rx[$];    // Replies the host should read
    int          gaps[$];      // Host idle cycles before each pop

    spi_subsystem spi_subsystem_inst (.*);

    spi_slave_model slave_inst (
        .reset (reset),
        .pins  (pins),
        .miso  (miso)
    );

    initial begin
        inner_clk = 1'b0;
        forever #2 inner_clk = ~inner_clk;
    end

    always @(posedge inner_clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, a frame or reply never came", CYCLE_LIMIT);
            $display("Errors: %0d value, %0d other", value_errors, other_errors + 1);
            $display("Test failed");
            $finish;
        end
    end

    // Galois LFSR, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return val;
    endfunction

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] want);
        $display("CHECK FAILED %s: got %h, expected %h", name, got, want);
        value_errors++;
    endtask

    task automatic report_problem(string msg);
        $display("ERROR: %s", msg);
        other_errors++;
    endtask

    // Queue a word and the reply the slave sends back for it
    task automatic push_word();
        spi_word_t tx_w;
        spi_word_t rx_w;
        tx_w = spi_word_t'(rand_bits(`SPI_WORD_BITS));
        rx_w = spi_word_t'(rand_bits(`SPI_WORD_BITS));
        gaps.push_back(int'(rand_bits(2)));
        while (tx_full) @(negedge inner_clk);
        exp_mosi.push_back(tx_w);
        exp_rx.push_back(rx_w);
        slave_inst.miso_words.push_back(rx_w);
        tx_push = 1'b1;
        tx_data = tx_w;
        @(negedge inner_clk);
        tx_push = 1'b0;
    endtask

    // Wait for a reply, check it and the frame behind it, then pop it
    task automatic pop_word();
        spi_word_t want_mosi;
        spi_word_t want_rx;
        spi_word_t got_mosi;
        int        rises;
        while (rx_empty) @(negedge inner_clk);
        repeat (gaps.pop_front()) @(negedge inner_clk);  // Host idle gap
        want_mosi = exp_mosi.pop_front();
        want_rx   = exp_rx.pop_front();
        if (slave_inst.mosi_frames.size() == 0) begin
            report_problem("reply arrived without a frame on the bus");
        end else begin
            got_mosi = slave_inst.mosi_frames.pop_front();
            rises    = slave_inst.rise_counts.pop_front();
            if (got_mosi !== want_mosi)
                report_mismatch("mosi", 32'(got_mosi), 32'(want_mosi));
            if (rises != `SPI_WORD_BITS)
                report_mismatch("sclk_rises", 32'(rises), 32'(`SPI_WORD_BITS));
        end
        if (rx_data !== want_rx)
            report_mismatch("rx_data", 32'(rx_data), 32'(want_rx));
        rx_pop = 1'b1;
        @(negedge inner_clk);
        rx_pop = 1'b0;
    endtask

    initial begin
        reset   = 1'b1;
        tx_push = 1'b0;
        tx_data = '0;
        rx_pop  = 1'b0;
        lfsr    = 32'he139_415c;
        repeat (4) @(posedge inner_clk);
        @(negedge inner_clk);
        reset = 1'b0;
        @(negedge inner_clk);
        if (pins.cs !== CS_IDLE)
            report_mismatch("cs", 32'(pins.cs), 32'(CS_IDLE));
        if (pins.sclk !== 1'b1)
            report_mismatch("sclk", 32'(pins.sclk), 32'h1);
        if (rx_empty !== 1'b1)
            report_mismatch("rx_empty", 32'(rx_empty), 32'h1);
        if (tx_full !== 1'b0)
            report_mismatch("tx_full", 32'(tx_full), 32'h0);
        push_word();
        pop_word();
        fork
            repeat (STREAM_WORDS) push_word();
            repeat (STREAM_WORDS) pop_word();
        join
        // Fill the receive queue and hold off the host
        base = slave_inst.frame_total;
        repeat (HOLD_WORDS) push_word();
        while (slave_inst.frame_total < base + `SPI_FIFO_DEPTH) @(negedge inner_clk);
        restarted = 1'b0;
        repeat (3 * FRAME_CYCLES) begin
            @(negedge inner_clk);
            if (pins.cs !== CS_IDLE)
                restarted = 1'b1;
        end
        if (restarted || slave_inst.frame_total != base + `SPI_FIFO_DEPTH)
            report_problem("a frame started while the receive queue was full");
        repeat (HOLD_WORDS) pop_word();
        if (rx_empty !== 1'b1)
            report_mismatch("rx_empty", 32'(rx_empty), 32'h1);
        if (slave_inst.mosi_frames.size() != 0)
            report_problem("frames left over after the final drain");
        other_errors += spi_subsystem_inst.spi_master_inst.spi_assert_inst.fail_count;
        $display("Errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/spi_fifo.sv
`timescale 1ns/1ns
`default_nettype none

`include "spi_config.svh"

module spi_fifo import spi_pkg::*; (
    input  wire logic      inner_clk,
    input  wire logic      reset,
    input  wire logic      push,
    input  wire spi_word_t push_data,
    input  wire logic      pop,
    output spi_word_t      head,
    output logic           empty,
    output logic           full
);

    localparam int DEPTH = `SPI_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    spi_word_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;   // Dropped when full
    assign do_pop  = pop && !empty;   // Dropped when empty

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));
    assign head  = mem[rd_ptr];

    always_ff @(posedge inner_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge inner_clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;  // Wraps, depth is a power of two
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves count unchanged
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/spi_master.sv
`timescale 1ns/1ns
`default_nettype none

`include "spi_config.svh"

module spi_master import spi_pkg::*; (
    input  wire logic      inner_clk,
    input  wire logic      reset,
    input  wire logic      tick,
    input  wire spi_word_t tx_word,
    input  wire logic      tx_empty,
    input  wire logic      rx_full,
    input  wire logic      miso,
    output logic           tx_take,
    output logic           rx_put,
    output spi_word_t      rx_word,
    output logic           busy,
    output spi_pins_t      pins
);

    localparam int        WORD_BITS = `SPI_WORD_BITS;
    localparam logic [4:0] HALF_LAST = 5'(2 * WORD_BITS - 1);

    spi_state_t state;
    spi_word_t  tx_sr;
    spi_word_t  rx_sr;
    logic [4:0] half_cnt;
    logic       start_ok;
    logic       shift_fall;
    logic       shift_rise;

    // A frame needs a word to send and room for the reply
    assign start_ok = !tx_empty && !rx_full;

    assign tx_take = tick && (state == idle) && start_ok;
    assign rx_put  = tick && (state == done);
    assign rx_word = rx_sr;
    assign busy    = (state != idle) || start_ok;  // Keeps the rate generator running

    // Even count is the falling half, odd count the rising half
    assign shift_fall = tick && (state == shift) && !half_cnt[0];
    assign shift_rise = tick && (state == shift) && half_cnt[0];

    always_ff @(posedge inner_clk or posedge reset) begin
        if (reset) begin
            state     <= idle;
            half_cnt  <= '0;
            pins.sclk <= 1'b1;
            pins.mosi <= 1'b0;
            pins.cs   <= ~`SPI_CS_ACTIVE;
        end else if (tick) begin
            case (state)
                idle: begin
                    if (start_ok) begin
                        state <= select;
                    end
                end
                select: begin
                    pins.cs  <= `SPI_CS_ACTIVE;
                    half_cnt <= '0;
                    state    <= shift;
                end
                shift: begin
                    half_cnt <= half_cnt + 1'b1;
                    if (!half_cnt[0]) begin
                        pins.sclk <= 1'b0;      // Slave drives miso here
                        pins.mosi <= tx_sr[0];  // LSB first
                    end else begin
                        pins.sclk <= 1'b1;      // Slave samples mosi here
                    end
                    if (half_cnt == HALF_LAST) begin
                        state <= done;
                    end
                end
                done: begin
                    pins.cs   <= ~`SPI_CS_ACTIVE;
                    pins.mosi <= 1'b0;
                    state     <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge inner_clk) begin
        if (tx_take) begin
            tx_sr <= tx_word;  // Head is valid while the pop is issued
        end else if (shift_fall) begin
            tx_sr <= tx_sr >> 1;
        end
        if (shift_rise) begin
            // First bit in walks down to bit 0
            rx_sr <= {miso, rx_sr[WORD_BITS-1:1]};
        end
    end

endmodule

`default_nettype wire

// File: verilog/spi_pkg.sv
`default_nettype none

`include "spi_config.svh"

package spi_pkg;

    // One frame worth of data
    typedef logic [`SPI_WORD_BITS-1:0] spi_word_t;

    // Off-chip master pins
    typedef struct packed {
        logic sclk;  // Idles high
        logic mosi;  // Changes after falling sclk
        logic cs;    // Single slave select
    } spi_pins_t;

    // Frame sequencer states
    typedef enum logic [1:0] {
        idle,
        select,
        shift,
        done
    } spi_state_t;

endpackage

`default_nettype wire

// File: verilog/spi_rate_gen.sv
`timescale 1ns/1ns
`default_nettype none

`include "spi_config.svh"

module spi_rate_gen (
    input  wire logic inner_clk,
    input  wire logic reset,
    input  wire logic run,
    output logic      tick
);

    localparam int CNT_W = $clog2(`SPI_CLK_DIV + 1);
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(`SPI_CLK_DIV - 1);

    logic [CNT_W-1:0] count;

    // Down counter, parked at the reload value while stopped
    always_ff @(posedge inner_clk or posedge reset) begin
        if (reset) begin
            count <= RELOAD;
            tick  <= 1'b0;
        end else if (!run) begin
            count <= RELOAD;  // Next start waits a full period
            tick  <= 1'b0;
        end else if (count == '0) begin
            count <= RELOAD;
            tick  <= 1'b1;    // One strobe per period
        end else begin
            count <= count - 1'b1;
            tick  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/spi_subsystem.sv
`timescale 1ns/1ns
`default_nettype none

module spi_subsystem import spi_pkg::*; (
    input  wire logic      inner_clk,
    input  wire logic      reset,
    input  wire logic      tx_push,
    input  wire spi_word_t tx_data,
    output logic           tx_full,
    input  wire logic      rx_pop,
    output spi_word_t      rx_data,
    output logic           rx_empty,
    input  wire logic      miso,
    output spi_pins_t      pins
);

    spi_word_t tx_head;
    logic      tx_empty;
    logic      tx_take;
    spi_word_t rx_word;
    logic      rx_put;
    logic      rx_full;
    logic      busy;
    logic      tick;

    // Host to master
    spi_fifo tx_fifo_inst (
        .inner_clk (inner_clk),
        .reset     (reset),
        .push      (tx_push),
        .push_data (tx_data),
        .pop       (tx_take),
        .head      (tx_head),
        .empty     (tx_empty),
        .full      (tx_full)
    );

    // Master to host
    spi_fifo rx_fifo_inst (
        .inner_clk (inner_clk),
        .reset     (reset),
        .push      (rx_put),
        .push_data (rx_word),
        .pop       (rx_pop),
        .head      (rx_data),
        .empty     (rx_empty),
        .full      (rx_full)
    );

    spi_rate_gen spi_rate_gen_inst (
        .inner_clk (inner_clk),
        .reset     (reset),
        .run       (busy),
        .tick      (tick)
    );

    spi_master spi_master_inst (
        .inner_clk (inner_clk),
        .reset     (reset),
        .tick      (tick),
        .tx_word   (tx_head),
        .tx_empty  (tx_empty),
        .rx_full   (rx_full),
        .miso      (miso),
        .tx_take   (tx_take),
        .rx_put    (rx_put),
        .rx_word   (rx_word),
        .busy      (busy),
        .pins      (pins)
    );

endmodule

`default_nettype wire
